// ==== build.f ====
+incdir+hw
hw/xc_pkg.sv
hw/link_pkg.sv
hw/pulse_delay_line.sv
hw/coincidence_counter.sv
hw/correlator_array.sv
hw/packet_framer.sv
hw/uart_tx.sv
hw/xc_top.sv
verif/xc_assert.sv
verif/xc_tb.sv

// ==== hw/coincidence_counter.sv ====
/*
 * Saturating counter of one coincidence strobe. The count type is a
 * parameter so the same block serves spectrum and correlation counts.
 */

`default_nettype none

module coincidence_counter #(
	parameter type count_t = logic [7:0]
) (
	input logic pll_clk,
	input logic arst_n,
	input logic hit,
	input logic clear,
	output count_t count
);

	localparam count_t COUNT_MAX = '1;

	logic at_max;

	assign at_max = (count == COUNT_MAX);

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (clear) begin
			// a new window already includes the sample that opens it
			count <= count_t'(hit);
		end else if (hit && !at_max) begin
			count <= count + count_t'(1);
		end
	end

endmodule

`default_nettype wire

// ==== hw/correlator_array.sv ====
/*
 * Window timer and all auto and cross coincidence counters. The count
 * registers are shown on spectra and correlations, and snapshot_valid
 * marks the cycle where they hold the final counts of a window.
 */

`include "xc_consts.svh"

`default_nettype none

module correlator_array (
	input logic pll_clk,
	input logic arst_n,
	input logic enable,
	input xc_pkg::sample_t line_in,
	output logic snapshot_valid,
	output logic [`NUM_SPECTRA*$bits(xc_pkg::spectrum_count_t)-1:0] spectra,
	output logic [`NUM_CORRELATIONS*$bits(xc_pkg::correlation_count_t)-1:0] correlations
);

	localparam int N = `NUM_INPUTS;
	localparam int L = `MAX_LAG;
	localparam xc_pkg::lag_t NUM_TAPS = xc_pkg::lag_t'(2 * `MAX_LAG - 1);
	localparam int SW = $bits(xc_pkg::spectrum_count_t);
	localparam int CW = $bits(xc_pkg::correlation_count_t);
	localparam int CNT_W = $clog2(`WINDOW_CYCLES);

	logic [NUM_TAPS*N-1:0] history;
	logic [CNT_W-1:0] sample_cnt;
	logic window_first;
	logic window_last;

	pulse_delay_line pulse_delay_line_inst (
		.pll_clk(pll_clk),
		.arst_n(arst_n),
		.shift(enable),
		.sample(line_in),
		.history(history)
	);

	// ------------------------------------------------------------------------
	// window timer
	// ------------------------------------------------------------------------

	assign window_first = enable && (sample_cnt == '0);
	assign window_last = enable && (sample_cnt == CNT_W'(`WINDOW_CYCLES - 1));

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			sample_cnt <= '0;
			snapshot_valid <= 1'b0;
		end else begin
			// counters take the last sample on this edge, so the flag lines
			// up with the registers holding the final counts
			snapshot_valid <= window_last;
			if (window_last) begin
				sample_cnt <= '0;
			end else if (enable) begin
				sample_cnt <= sample_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// autocorrelation, input a against its own tap k
	// ------------------------------------------------------------------------

	for (genvar a = 0; a < N; a++) begin : g_auto
		for (genvar k = 0; k < L; k++) begin : g_lag
			logic hit;

			assign hit = enable & history[a] & history[k*N+a];

			coincidence_counter #(
				.count_t(xc_pkg::spectrum_count_t)
			) spectrum_counter_inst (
				.pll_clk(pll_clk),
				.arst_n(arst_n),
				.hit(hit),
				.clear(window_first),
				.count(spectra[(a*L+k)*SW +: SW])
			);
		end
	end

	// ------------------------------------------------------------------------
	// cross-correlation, baseline (a,b) at lag d
	// ------------------------------------------------------------------------

	for (genvar a = 0; a < N; a++) begin : g_cross_a
		for (genvar b = a + 1; b < N; b++) begin : g_cross_b
			for (genvar j = 0; j < 2 * L - 1; j++) begin : g_lag
				localparam int D = j - (L - 1);
				localparam int BL = a * (2 * N - a - 1) / 2 + (b - a - 1);

				logic hit;

				// positive lags delay input a, negative lags delay input b
				if (D >= 0) begin : g_pos
					assign hit = enable & history[D*N+a] & history[b];
				end else begin : g_neg
					assign hit = enable & history[a] & history[(-D)*N+b];
				end

				coincidence_counter #(
					.count_t(xc_pkg::correlation_count_t)
				) correlation_counter_inst (
					.pll_clk(pll_clk),
					.arst_n(arst_n),
					.hit(hit),
					.clear(window_first),
					.count(correlations[(BL*(2*L-1)+j)*CW +: CW])
				);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/link_pkg.sv ====
/*
 * Types of the serial link: bytes, packet positions and the framer FSM.
 * Shared by the framer, the transmitter and the bound assertions.
 */

`include "xc_consts.svh"

`default_nettype none

package link_pkg;

	typedef logic [7:0] byte_t;

	// position within one packet, header included
	typedef logic [$clog2(`PACKET_BYTES + 1)-1:0] byte_index_t;

	// IDLE waits for a snapshot, SEND offers the current byte,
	// WAIT lets the last byte leave the transmitter
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		SEND = 2'd1,
		WAIT = 2'd2
	} framer_state_t;

endpackage

`default_nettype wire

// ==== hw/packet_framer.sv ====
/*
 * Latches a count snapshot and hands it byte by byte to the UART
 * transmitter: four header bytes, the spectra, then the correlations.
 */

`include "xc_consts.svh"

`default_nettype none

module packet_framer (
	input logic pll_clk,
	input logic arst_n,
	input logic snapshot_valid,
	input logic [`NUM_SPECTRA*$bits(xc_pkg::spectrum_count_t)-1:0] spectra,
	input logic [`NUM_CORRELATIONS*$bits(xc_pkg::correlation_count_t)-1:0] correlations,
	input logic tx_ready,
	output logic tx_start,
	output link_pkg::byte_t tx_byte,
	output logic tx_busy
);

	localparam int SW = $bits(xc_pkg::spectrum_count_t);
	localparam int CW = $bits(xc_pkg::correlation_count_t);
	localparam int NS = `NUM_SPECTRA;
	localparam int NC = `NUM_CORRELATIONS;
	localparam int PB = `PACKET_BYTES;

	link_pkg::framer_state_t state;
	link_pkg::byte_index_t idx;
	logic lost_pending;
	logic lost_q;
	logic accept;
	logic last_byte;

	xc_pkg::spectrum_count_t spec_q [NS];
	xc_pkg::correlation_count_t corr_q [NC];

	assign accept = snapshot_valid && (state == link_pkg::IDLE);
	assign last_byte = (idx == link_pkg::byte_index_t'(PB - 1));
	assign tx_start = (state == link_pkg::SEND) && tx_ready;
	assign tx_busy = (state != link_pkg::IDLE);

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= link_pkg::IDLE;
			idx <= '0;
			lost_pending <= 1'b0;
			lost_q <= 1'b0;
		end else begin
			// a snapshot that finds us busy is dropped and reported later
			if (snapshot_valid && state != link_pkg::IDLE) begin
				lost_pending <= 1'b1;
			end
			case (state)
				link_pkg::IDLE: begin
					if (snapshot_valid) begin
						state <= link_pkg::SEND;
						idx <= '0;
						lost_q <= lost_pending;
						lost_pending <= 1'b0;
					end
				end
				link_pkg::SEND: begin
					if (tx_ready) begin
						if (last_byte) begin
							state <= link_pkg::WAIT;
						end else begin
							idx <= idx + 1'b1;
						end
					end
				end
				default: begin
					if (tx_ready) begin
						state <= link_pkg::IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge pll_clk) begin
		if (accept) begin
			for (int i = 0; i < NS; i++) begin
				spec_q[i] <= spectra[i*SW +: SW];
			end
			for (int i = 0; i < NC; i++) begin
				corr_q[i] <= correlations[i*CW +: CW];
			end
		end
	end

	// byte at the current packet position
	always_comb begin
		int pos;
		pos = int'(idx);
		if (pos == 0) begin
			tx_byte = `SYNC_BYTE;
		end else if (pos == 1) begin
			tx_byte = link_pkg::byte_t'(`NUM_INPUTS);
		end else if (pos == 2) begin
			tx_byte = link_pkg::byte_t'(`MAX_LAG);
		end else if (pos == 3) begin
			tx_byte = {4'(`RESOLUTION), 3'b000, lost_q};
		end else if (pos < 4 + NS) begin
			tx_byte = link_pkg::byte_t'(spec_q[pos-4]);
		end else if (pos < PB) begin
			tx_byte = link_pkg::byte_t'(corr_q[pos-4-NS]);
		end else begin
			tx_byte = '0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/pulse_delay_line.sv ====
/*
 * History of the sampled pulse vector. Tap 0 is the incoming sample,
 * tap k the sample taken k shifts earlier.
 */

`include "xc_consts.svh"

`default_nettype none

module pulse_delay_line (
	input logic pll_clk,
	input logic arst_n,
	input logic shift,
	input xc_pkg::sample_t sample,
	output logic [(2*`MAX_LAG-1)*`NUM_INPUTS-1:0] history
);

	localparam xc_pkg::lag_t NUM_TAPS = xc_pkg::lag_t'(2 * `MAX_LAG - 1);
	localparam int SAMPLE_W = $bits(xc_pkg::sample_t);

	// past samples only, the current one is passed straight through
	xc_pkg::sample_t past [1:NUM_TAPS-1];

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < NUM_TAPS; i++) begin
				past[i] <= '0;
			end
		end else if (shift) begin
			past[1] <= sample;
			for (int i = 2; i < NUM_TAPS; i++) begin
				past[i] <= past[i-1];
			end
		end
	end

	assign history[0 +: SAMPLE_W] = sample;

	for (genvar k = 1; k < NUM_TAPS; k++) begin : g_tap
		assign history[k*SAMPLE_W +: SAMPLE_W] = past[k];
	end

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
/*
 * 8N1 UART transmitter with a fixed divider of BAUD_DIV clocks per bit.
 * A byte is taken on tx_start while tx_ready is high, LSB first.
 */

`include "xc_consts.svh"

`default_nettype none

module uart_tx (
	input logic pll_clk,
	input logic arst_n,
	input logic tx_start,
	input link_pkg::byte_t tx_byte,
	output logic tx_ready,
	output logic tx
);

	localparam int BAUD_W = $clog2(`BAUD_DIV + 1);

	logic busy;
	logic [BAUD_W-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	// stop, data and start bits, shifted out from bit 0
	logic [9:0] frame;
	logic bit_end;

	assign bit_end = (baud_cnt == BAUD_W'(`BAUD_DIV - 1));
	assign tx_ready = !busy;
	// line idles high between frames
	assign tx = busy ? frame[0] : 1'b1;

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (tx_start) begin
				busy <= 1'b1;
				baud_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge pll_clk) begin
		if (!busy && tx_start) begin
			frame <= {1'b1, tx_byte, 1'b0};
		end else if (busy && bit_end) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

endmodule

`default_nettype wire

// ==== hw/xc_consts.svh ====
/*
 * Build-time sizes of the pulse correlator and its serial link.
 * Include this wherever a module or package needs them.
 */

`ifndef XC_CONSTS_SVH
`define XC_CONSTS_SVH

// pulse inputs and lag range
`define NUM_INPUTS 3
`define MAX_LAG 4

// count width in bits, one byte per count at most
`define RESOLUTION 8

// enabled samples per integration window
`define WINDOW_CYCLES 1600

// serial link
`define BAUD_DIV 4
`define SYNC_BYTE 8'hA5

// derived sizes
`define NUM_BASELINES (`NUM_INPUTS * (`NUM_INPUTS - 1) / 2)
`define NUM_SPECTRA (`NUM_INPUTS * `MAX_LAG)
`define NUM_CORRELATIONS (`NUM_BASELINES * (2 * `MAX_LAG - 1))
`define PACKET_BYTES (4 + `NUM_SPECTRA + `NUM_CORRELATIONS)

`endif

// ==== hw/xc_pkg.sv ====
/*
 * Types of the correlator datapath: sample vectors, lag indices and counts.
 * Referenced by scoped name from the delay line, the array and the framer.
 */

`include "xc_consts.svh"

`default_nettype none

package xc_pkg;

	// one bit per pulse input, bit a belongs to input a
	typedef logic [`NUM_INPUTS-1:0] sample_t;

	// wide enough to hold any tap number up to 2*MAX_LAG
	typedef logic [$clog2(2 * `MAX_LAG + 1)-1:0] lag_t;

	// the two count kinds are kept apart so their widths can be tuned separately
	typedef logic [`RESOLUTION-1:0] spectrum_count_t;
	typedef logic [`RESOLUTION-1:0] correlation_count_t;

endpackage

`default_nettype wire

// ==== hw/xc_top.sv ====
/*
 * Top level of the correlator core: counts pulse coincidences over a
 * window and ships each snapshot as a UART packet on tx.
 */

`include "xc_consts.svh"

`default_nettype none

module xc_top (
	input logic pll_clk,
	input logic arst_n,
	input logic enable,
	input xc_pkg::sample_t line_in,
	output logic tx,
	output logic tx_busy
);

	logic snapshot_valid;
	logic [`NUM_SPECTRA*$bits(xc_pkg::spectrum_count_t)-1:0] spectra;
	logic [`NUM_CORRELATIONS*$bits(xc_pkg::correlation_count_t)-1:0] correlations;
	logic tx_start;
	logic tx_ready;
	link_pkg::byte_t tx_byte;

	// ------------------------------------------------------------------------
	// counting core
	// ------------------------------------------------------------------------

	correlator_array correlator_array_inst (
		.pll_clk(pll_clk),
		.arst_n(arst_n),
		.enable(enable),
		.line_in(line_in),
		.snapshot_valid(snapshot_valid),
		.spectra(spectra),
		.correlations(correlations)
	);

	// ------------------------------------------------------------------------
	// packet output
	// ------------------------------------------------------------------------

	packet_framer packet_framer_inst (
		.pll_clk(pll_clk),
		.arst_n(arst_n),
		.snapshot_valid(snapshot_valid),
		.spectra(spectra),
		.correlations(correlations),
		.tx_ready(tx_ready),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_busy(tx_busy)
	);

	uart_tx uart_tx_inst (
		.pll_clk(pll_clk),
		.arst_n(arst_n),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready),
		.tx(tx)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the correlator testbench with Verilator, runs it and looks for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module xc_tb -f build.f -Mdir obj_dir \
	&& ./obj_dir/Vxc_tb | tee /dev/stderr | grep -q "Test completed successfully" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// ==== verif/xc_assert.sv ====
/*
 * Protocol checks on the correlator top level, attached by bind.
 * Watches the idle line, the transmitter strobe and the snapshot spacing.
 */

`include "xc_consts.svh"

`default_nettype none

module xc_assert (
	input logic pll_clk,
	input logic arst_n,
	input logic tx,
	input logic tx_start,
	input logic tx_ready,
	input logic snapshot_valid,
	input link_pkg::framer_state_t framer_state
);

	localparam int GAP_W = $clog2(`WINDOW_CYCLES + 1);

	// counts cycles since the last snapshot and parks at the window length
	logic [GAP_W-1:0] since_snapshot;

	always_ff @(posedge pll_clk or negedge arst_n) begin
		if (!arst_n) begin
			since_snapshot <= GAP_W'(`WINDOW_CYCLES);
		end else if (snapshot_valid) begin
			since_snapshot <= '0;
		end else if (since_snapshot != GAP_W'(`WINDOW_CYCLES)) begin
			since_snapshot <= since_snapshot + 1'b1;
		end
	end

	tx_high_when_idle: assert property (@(posedge pll_clk) disable iff (!arst_n)
		(framer_state == link_pkg::IDLE) |-> tx)
		else $error("tx is low while the framer is idle");

	// the transmitter must be free for the strobe and busy on the next cycle
	start_taken_when_ready: assert property (@(posedge pll_clk) disable iff (!arst_n)
		tx_start |-> tx_ready ##1 !tx_ready)
		else $error("tx_start was raised while the transmitter was busy or was not taken");

	// a window holds WINDOW_CYCLES enabled samples, so snapshots are at least that far apart
	snapshot_spacing: assert property (@(posedge pll_clk) disable iff (!arst_n)
		snapshot_valid |-> (since_snapshot >= GAP_W'(`WINDOW_CYCLES - 1)))
		else $error("snapshot_valid repeated within one window");

endmodule

bind xc_top xc_assert xc_assert_inst (
	.pll_clk(pll_clk),
	.arst_n(arst_n),
	.tx(tx),
	.tx_start(tx_start),
	.tx_ready(tx_ready),
	.snapshot_valid(snapshot_valid),
	.framer_state(packet_framer_inst.state)
);

`default_nettype wire

// ==== verif/xc_tb.sv ====
/*
 * Testbench of the correlator core. Sparse LFSR pulses, an enable gap and a
 * saturating window are sent in; a UART decoder checks every packet byte
 * against a reference model of the coincidence counts.
 */

`include "xc_consts.svh"

`default_nettype none

module xc_tb;

	localparam int N = `NUM_INPUTS;
	localparam int L = `MAX_LAG;
	localparam int NT = 2 * `MAX_LAG - 1;
	localparam int NB = `NUM_BASELINES;
	localparam int NS = `NUM_SPECTRA;
	localparam int PB = `PACKET_BYTES;
	localparam int COUNT_MAX = (1 << `RESOLUTION) - 1;
	localparam int NUM_WINDOWS = 4;
	localparam int TIMEOUT_CYCLES = 6 * (`WINDOW_CYCLES + PB * 10 * `BAUD_DIV);

	logic pll_clk;
	logic arst_n;
	logic enable;
	xc_pkg::sample_t line_in;
	logic tx;
	logic tx_busy;

	logic [15:0] lfsr;
	xc_pkg::sample_t hist [1:NT-1];
	int spec_cnt [N][L];
	int corr_cnt [NB][NT];
	int model_samples;
	int windows_done;
	link_pkg::byte_t exp_bytes [$];
	int byte_pos;
	int packets_seen;
	int cycle_count;
	logic busy_q;

	xc_top xc_top_inst (
		.pll_clk(pll_clk),
		.arst_n(arst_n),
		.enable(enable),
		.line_in(line_in),
		.tx(tx),
		.tx_busy(tx_busy)
	);

	always #20 pll_clk = ~pll_clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	// 16-bit Galois LFSR that takes one step per bit handed out
	function automatic logic random_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 16'hB400;
		end
		return out;
	endfunction

	// a line pulses only when three LFSR bits are all set
	function automatic xc_pkg::sample_t random_sample();
		xc_pkg::sample_t s;
		logic b0;
		logic b1;
		logic b2;
		for (int a = 0; a < N; a++) begin
			b0 = random_bit();
			b1 = random_bit();
			b2 = random_bit();
			s[a] = b0 & b1 & b2;
		end
		return s;
	endfunction

	function automatic string byte_name(input int pos);
		int c;
		if (pos == 0) return "sync byte";
		if (pos == 1) return "input count byte";
		if (pos == 2) return "lag count byte";
		if (pos == 3) return "flag byte";
		if (pos < 4 + NS) begin
			return $sformatf("spectrum input %0d lag %0d", (pos - 4) / L, (pos - 4) % L);
		end
		c = pos - 4 - NS;
		return $sformatf("correlation baseline %0d lag %0d", c / NT, c % NT - (L - 1));
	endfunction

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	task automatic drive_window(input bit saturate, input int gap_at, input int gap_len);
		for (int n = 0; n < `WINDOW_CYCLES; n++) begin
			if (n == gap_at) begin
				// noise on the lines while disabled must not be counted
				repeat (gap_len) begin
					@(posedge pll_clk);
					enable <= 1'b0;
					line_in <= random_sample();
				end
			end
			@(posedge pll_clk);
			enable <= 1'b1;
			if (saturate) begin
				line_in <= '1;
			end else begin
				line_in <= random_sample();
			end
		end
	endtask

	initial begin
		pll_clk = 1'b0;
		arst_n = 1'b0;
		enable = 1'b0;
		line_in = '0;
		lfsr = 16'd12285;
		repeat (3) @(posedge pll_clk);
		arst_n <= 1'b1;
		drive_window(1'b0, -1, 0);
		drive_window(1'b0, -1, 0);
		drive_window(1'b0, 700, 37);
		drive_window(1'b1, -1, 0);
		@(posedge pll_clk);
		enable <= 1'b0;
		line_in <= '0;
		while (packets_seen < NUM_WINDOWS) begin
			@(posedge pll_clk);
		end
		repeat (4) @(posedge pll_clk);
		if (exp_bytes.size() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			abort_run($sformatf("%0d expected bytes were never sent", exp_bytes.size()));
		end
	end

	// ------------------------------------------------------------------------
	// reference model that counts on the same edge as the DUT samples
	// ------------------------------------------------------------------------

	always @(posedge pll_clk) begin : model
		xc_pkg::sample_t tap [0:NT-1];
		logic hit;
		int bl;
		int d;
		if (!arst_n) begin
			for (int k = 1; k < NT; k++) begin
				hist[k] = '0;
			end
		end else if (enable) begin
			tap[0] = line_in;
			for (int k = 1; k < NT; k++) begin
				tap[k] = hist[k];
			end
			for (int a = 0; a < N; a++) begin
				for (int k = 0; k < L; k++) begin
					if (tap[0][a] && tap[k][a] && spec_cnt[a][k] < COUNT_MAX) begin
						spec_cnt[a][k]++;
					end
				end
			end
			bl = 0;
			for (int a = 0; a < N; a++) begin
				for (int b = a + 1; b < N; b++) begin
					for (int j = 0; j < NT; j++) begin
						d = j - (L - 1);
						// a positive lag pairs the older a with the current b
						if (d >= 0) begin
							hit = tap[d][a] && tap[0][b];
						end else begin
							hit = tap[0][a] && tap[-d][b];
						end
						if (hit && corr_cnt[bl][j] < COUNT_MAX) begin
							corr_cnt[bl][j]++;
						end
					end
					bl++;
				end
			end
			for (int k = NT - 1; k > 1; k--) begin
				hist[k] = hist[k-1];
			end
			hist[1] = line_in;
			model_samples++;
			if (model_samples == `WINDOW_CYCLES) begin
				exp_bytes.push_back(`SYNC_BYTE);
				exp_bytes.push_back(link_pkg::byte_t'(N));
				exp_bytes.push_back(link_pkg::byte_t'(L));
				exp_bytes.push_back(link_pkg::byte_t'(`RESOLUTION << 4));
				for (int a = 0; a < N; a++) begin
					for (int k = 0; k < L; k++) begin
						exp_bytes.push_back(link_pkg::byte_t'(spec_cnt[a][k]));
						spec_cnt[a][k] = 0;
					end
				end
				for (int i = 0; i < NB; i++) begin
					for (int j = 0; j < NT; j++) begin
						exp_bytes.push_back(link_pkg::byte_t'(corr_cnt[i][j]));
						corr_cnt[i][j] = 0;
					end
				end
				model_samples = 0;
				windows_done++;
			end
		end
	end

	// ------------------------------------------------------------------------
	// UART decoder and packet checks
	// ------------------------------------------------------------------------

	task automatic check_received(input link_pkg::byte_t got);
		link_pkg::byte_t exp;
		if (exp_bytes.size() == 0) begin
			abort_run($sformatf("byte %02h arrived on tx when no packet was due", got));
		end else begin
			exp = exp_bytes.pop_front();
			assert (got == exp)
				else abort_run($sformatf("Error at %0t: %s got %02h expected %02h",
					$time, byte_name(byte_pos), got, exp));
			byte_pos++;
		end
	endtask

	always begin : uart_decoder
		link_pkg::byte_t got;
		@(posedge pll_clk);
		if (arst_n && tx == 1'b0) begin
			repeat (`BAUD_DIV / 2) @(posedge pll_clk);
			assert (tx == 1'b0)
				else abort_run("start bit on tx did not last to its centre");
			for (int i = 0; i < 8; i++) begin
				repeat (`BAUD_DIV) @(posedge pll_clk);
				got[i] = tx;
			end
			repeat (`BAUD_DIV) @(posedge pll_clk);
			assert (tx == 1'b1)
				else abort_run("stop bit on tx was low");
			check_received(got);
		end
	end

	// the end of tx_busy closes a packet
	always @(posedge pll_clk) begin
		busy_q <= tx_busy;
		if (arst_n && busy_q && !tx_busy) begin
			assert (byte_pos == PB)
				else abort_run($sformatf("Error at %0t: packet length got %0d expected %0d",
					$time, byte_pos, PB));
			byte_pos = 0;
			packets_seen++;
		end
	end

	quiet_before_first_window: assert property (@(posedge pll_clk) disable iff (!arst_n)
		(windows_done == 0) |-> (tx && !tx_busy))
		else abort_run("tx or tx_busy moved before the first window ended");

	always @(posedge pll_clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout after %0d cycles with %0d packets received",
				cycle_count, packets_seen));
		end
	end

endmodule

`default_nettype wire
